// ==== hw/bpu_pkg.sv ====
////////////////////
// Shared widths and record types for the branch prediction front end
// Referenced by scoped names from every RTL module and the testbench
////////////////////

`default_nettype none

package bpu_pkg;

    ////////////////////
    // Widths and sizes
    ////////////////////

    // Instruction address
    localparam int ADDR_WIDTH  = 32;
    // Most instructions in one block, 4 bytes each
    localparam int FETCH_WIDTH = 4;
    // Block length 1 to 4
    localparam int LEN_WIDTH   = 3;
    // Branch slot inside a block
    localparam int SLOT_WIDTH  = 2;
    // All PC bits above the line offset, the FTB uses the low part
    localparam int TAG_WIDTH   = ADDR_WIDTH - 4;

    ////////////////////
    // Records
    ////////////////////

    // One fetch block toward the fetch stage
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] start_pc;
        logic [LEN_WIDTH-1:0]  length;
        logic                  predicted_taken;
        logic                  cross_cacheline;
        logic [ADDR_WIDTH-1:0] next_pc;
    } fetch_block_t;

    // One FTB record
    typedef struct packed {
        logic                  valid;
        // Zero extended, width set by the table size
        logic [TAG_WIDTH-1:0]  tag;
        logic [SLOT_WIDTH-1:0] slot;
        logic [ADDR_WIDTH-1:0] target;
    } ftb_entry_t;

    // Resolved branch from the backend
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] start_pc;
        logic [SLOT_WIDTH-1:0] slot;
        logic [ADDR_WIDTH-1:0] target;
        logic                  taken;
    } bpu_train_t;

    // Backend redirect
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] pc;
    } bpu_redirect_t;

endpackage

`default_nettype wire

// ==== hw/ftb.sv ====
////////////////////
// Direct-mapped fetch target buffer
// Combinational lookup by block start PC, written by taken training updates
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ftb #(
    parameter int FTB_ENTRIES = 16
) (
    input  wire logic                                clk,
    input  wire logic                                rst_i,
    input  wire logic [bpu_pkg::ADDR_WIDTH-1:0]      query_pc_i,
    output logic                                     hit_o,
    output bpu_pkg::ftb_entry_t                      entry_o,
    input  wire bpu_pkg::bpu_train_t                 train_i
);

    localparam int AW    = bpu_pkg::ADDR_WIDTH;
    localparam int IDX_W = $clog2(FTB_ENTRIES);
    // Tag is everything above the index
    localparam int TAG_W = AW - IDX_W - 4;

    // Valid bit per entry
    logic [FTB_ENTRIES-1:0] valid_q;
    bpu_pkg::ftb_entry_t    entry_q [FTB_ENTRIES];

    logic [IDX_W-1:0]                  query_idx;
    logic [TAG_W-1:0]                  query_tag;
    logic [IDX_W-1:0]                  train_idx;
    logic [bpu_pkg::TAG_WIDTH-1:0]     train_tag;
    logic                              train_write;
    bpu_pkg::ftb_entry_t               rd_entry;

    ////////////////////
    // Lookup
    ////////////////////

    // Index starts above the 16 byte line offset
    assign query_idx = query_pc_i[IDX_W+3:4];
    assign query_tag = query_pc_i[AW-1 -: TAG_W];

    always_comb begin
        rd_entry       = entry_q[query_idx];
        // Stored valid field is replaced by the live bit
        rd_entry.valid = valid_q[query_idx];
    end

    assign entry_o = rd_entry;
    assign hit_o   = rd_entry.valid && (rd_entry.tag[TAG_W-1:0] == query_tag);

    ////////////////////
    // Training write
    ////////////////////

    // Only taken branches allocate
    assign train_write = train_i.valid && train_i.taken;
    assign train_idx   = train_i.start_pc[IDX_W+3:4];
    assign train_tag   = bpu_pkg::TAG_WIDTH'(train_i.start_pc[AW-1 -: TAG_W]);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (train_write) begin
            valid_q[train_idx] <= 1'b1;
        end
    end

    // Same cycle lookup still sees the old payload
    always_ff @(posedge clk) begin
        if (train_write) begin
            entry_q[train_idx].tag    <= train_tag;
            entry_q[train_idx].slot   <= train_i.slot;
            entry_q[train_idx].target <= train_i.target;
        end
    end

endmodule

`default_nettype wire

// ==== hw/bimodal_predictor.sv ====
////////////////////
// Bimodal direction predictor
// 2-bit saturating counters, high bit gives the taken prediction
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bimodal_predictor #(
    parameter int BHT_ENTRIES = 64
) (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    input  wire logic [bpu_pkg::ADDR_WIDTH-1:0] query_pc_i,
    output logic                                taken_o,
    input  wire bpu_pkg::bpu_train_t            train_i
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    // Weakly not taken after reset
    localparam logic [1:0] CTR_INIT = 2'b01;

    logic [1:0]       ctr_q [BHT_ENTRIES];
    logic [IDX_W-1:0] query_idx;
    logic [IDX_W-1:0] train_idx;
    logic [1:0]       train_ctr;
    logic [1:0]       train_ctr_nxt;

    ////////////////////
    // Lookup
    ////////////////////

    // Index above the instruction byte offset
    assign query_idx = query_pc_i[IDX_W+1:2];
    assign taken_o   = ctr_q[query_idx][1];

    ////////////////////
    // Counter update
    ////////////////////

    assign train_idx = train_i.start_pc[IDX_W+1:2];
    assign train_ctr = ctr_q[train_idx];

    // One step toward the outcome, held at 0 and 3
    always_comb begin
        train_ctr_nxt = train_ctr;
        if (train_i.taken) begin
            if (train_ctr != 2'b11) begin
                train_ctr_nxt = train_ctr + 2'b01;
            end
        end else begin
            if (train_ctr != 2'b00) begin
                train_ctr_nxt = train_ctr - 2'b01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (train_i.valid) begin
            ctr_q[train_idx] <= train_ctr_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch_block_gen.sv ====
////////////////////
// Fetch PC register and block formation
// Cuts at page end, flags line crossing, picks target or fall-through
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_block_gen #(
    parameter logic [bpu_pkg::ADDR_WIDTH-1:0] RESET_PC = 32'h8000_0000
) (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    output logic [bpu_pkg::ADDR_WIDTH-1:0]      query_pc_o,
    input  wire logic                           ftb_hit_i,
    input  wire bpu_pkg::ftb_entry_t            ftb_entry_i,
    input  wire logic                           taken_i,
    input  wire bpu_pkg::bpu_redirect_t         redirect_i,
    output logic                                push_valid_o,
    output bpu_pkg::fetch_block_t               push_block_o,
    input  wire logic                           push_ready_i
);

    localparam int AW = bpu_pkg::ADDR_WIDTH;
    localparam int LW = bpu_pkg::LEN_WIDTH;

    logic [AW-1:0] pc_q;
    logic          use_branch;
    logic          page_cut;
    // Bytes left in the 4 KB page
    logic [12:0]   page_rem;
    logic [LW-1:0] blk_len;
    logic [LW:0]   line_end;
    logic [AW-1:0] fall_through;
    logic          push_fire;

    // Table lookups run off the PC register directly
    assign query_pc_o = pc_q;

    ////////////////////
    // Block length
    ////////////////////

    assign use_branch = ftb_hit_i & taken_i;
    assign page_cut   = pc_q[11:0] > 12'hff0;
    assign page_rem   = 13'h1000 - {1'b0, pc_q[11:0]};

    always_comb begin
        if (use_branch) begin
            // Block ends on the branch
            blk_len = LW'(ftb_entry_i.slot) + LW'(1);
        end else if (page_cut) begin
            blk_len = page_rem[LW+1:2];
        end else begin
            blk_len = LW'(bpu_pkg::FETCH_WIDTH);
        end
    end

    // Line offset in instructions plus length
    assign line_end     = (LW+1)'(pc_q[3:2]) + (LW+1)'(blk_len);
    assign fall_through = pc_q + AW'({blk_len, 2'b00});

    ////////////////////
    // Block output
    ////////////////////

    always_comb begin
        push_block_o.start_pc        = pc_q;
        push_block_o.length          = blk_len;
        push_block_o.predicted_taken = use_branch;
        push_block_o.cross_cacheline = line_end > (LW+1)'(4);
        push_block_o.next_pc         = use_branch ? ftb_entry_i.target : fall_through;
    end

    // Nothing offered while the backend redirects
    assign push_valid_o = ~redirect_i.valid;
    assign push_fire    = push_valid_o & push_ready_i;

    ////////////////////
    // PC register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.pc;
        end else if (push_fire) begin
            pc_q <= push_block_o.next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ftq.sv ====
////////////////////
// Fetch target queue
// Circular FIFO of fetch blocks, valid/ready on both sides, flushed on redirect
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ftq #(
    parameter int FTQ_DEPTH = 4
) (
    input  wire logic                  clk,
    input  wire logic                  rst_i,
    input  wire logic                  flush_i,
    input  wire logic                  push_valid_i,
    input  wire bpu_pkg::fetch_block_t push_block_i,
    output logic                       push_ready_o,
    output logic                       pop_valid_o,
    output bpu_pkg::fetch_block_t      pop_block_o,
    input  wire logic                  pop_ready_i
);

    localparam int PTR_W = $clog2(FTQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    bpu_pkg::fetch_block_t mem_q [FTQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_fire;
    logic             pop_fire;

    // Full and empty from the occupancy count
    assign push_ready_o = count_q != CNT_W'(FTQ_DEPTH);
    assign pop_valid_o  = count_q != '0;
    // Head slot read directly
    assign pop_block_o  = mem_q[rd_ptr_q];

    assign push_fire = push_valid_i & push_ready_o;
    assign pop_fire  = pop_valid_o & pop_ready_i;

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                // Wrap also for a depth that is not a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FTQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FTQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    ////////////////////
    // Storage
    ////////////////////

    // Push dropped while flushing
    always_ff @(posedge clk) begin
        if (push_fire && !flush_i) begin
            mem_q[wr_ptr_q] <= push_block_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/bpu_top.sv ====
////////////////////
// Branch prediction front end top level
// Block generator, FTB, bimodal table and fetch target queue
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bpu_top #(
    parameter logic [bpu_pkg::ADDR_WIDTH-1:0] RESET_PC    = 32'h8000_0000,
    parameter int                             FTB_ENTRIES = 16,
    parameter int                             BHT_ENTRIES = 64,
    parameter int                             FTQ_DEPTH   = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    // Backend
    input  wire bpu_pkg::bpu_train_t    train_i,
    input  wire bpu_pkg::bpu_redirect_t redirect_i,
    // Fetch stage
    input  wire logic                   fetch_ready_i,
    output logic                        fetch_valid_o,
    output bpu_pkg::fetch_block_t       fetch_block_o
);

    logic [bpu_pkg::ADDR_WIDTH-1:0] query_pc;
    logic                           ftb_hit;
    bpu_pkg::ftb_entry_t            ftb_entry;
    logic                           bht_taken;
    logic                           push_valid;
    bpu_pkg::fetch_block_t          push_block;
    logic                           push_ready;

    fetch_block_gen #(
        .RESET_PC (RESET_PC)
    ) u_fetch_block_gen (
        .clk          (clk),
        .rst_i        (rst_i),
        .query_pc_o   (query_pc),
        .ftb_hit_i    (ftb_hit),
        .ftb_entry_i  (ftb_entry),
        .taken_i      (bht_taken),
        .redirect_i   (redirect_i),
        .push_valid_o (push_valid),
        .push_block_o (push_block),
        .push_ready_i (push_ready)
    );

    ftb #(
        .FTB_ENTRIES (FTB_ENTRIES)
    ) u_ftb (
        .clk        (clk),
        .rst_i      (rst_i),
        .query_pc_i (query_pc),
        .hit_o      (ftb_hit),
        .entry_o    (ftb_entry),
        .train_i    (train_i)
    );

    bimodal_predictor #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) u_bimodal_predictor (
        .clk        (clk),
        .rst_i      (rst_i),
        .query_pc_i (query_pc),
        .taken_o    (bht_taken),
        .train_i    (train_i)
    );

    // Redirect empties the queue
    ftq #(
        .FTQ_DEPTH (FTQ_DEPTH)
    ) u_ftq (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (redirect_i.valid),
        .push_valid_i (push_valid),
        .push_block_i (push_block),
        .push_ready_o (push_ready),
        .pop_valid_o  (fetch_valid_o),
        .pop_block_o  (fetch_block_o),
        .pop_ready_i  (fetch_ready_i)
    );

endmodule

`default_nettype wire

// ==== testbench/bpu_checker.sv ====
////////////////////
// Reference model and scoreboard for the branch prediction front end
// Tracks tables, fetch PC and queue from the block rules, checks each accepted block
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bpu_checker #(
    parameter logic [31:0] RESET_PC    = 32'h8000_0000,
    parameter int          FTB_ENTRIES = 16,
    parameter int          BHT_ENTRIES = 64,
    parameter int          FTQ_DEPTH   = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire bpu_pkg::bpu_train_t    train_i,
    input  wire bpu_pkg::bpu_redirect_t redirect_i,
    input  wire logic                   ready_i,
    input  wire logic                   valid_i,
    input  wire bpu_pkg::fetch_block_t  block_i,
    input  wire logic [8*24-1:0]        test_name_i,
    output int                          checked_o,
    output int                          errors_o
);

    ////////////////////
    // Model state
    ////////////////////

    logic                  ftb_valid  [FTB_ENTRIES];
    logic [31:0]           ftb_tag    [FTB_ENTRIES];
    logic [1:0]            ftb_slot   [FTB_ENTRIES];
    logic [31:0]           ftb_target [FTB_ENTRIES];
    int                    ctr        [BHT_ENTRIES];
    logic [31:0]           model_pc;
    // Blocks pushed but not yet taken by the fetch stage
    bpu_pkg::fetch_block_t pending [$];
    // Start PC owed by the first block after a redirect
    logic                  redirect_seen;
    logic [31:0]           redirect_pc;

    // Block formed from a PC with the current table contents
    function automatic bpu_pkg::fetch_block_t predict_block(input logic [31:0] pc);
        bpu_pkg::fetch_block_t blk;
        int                    fi;
        int                    bi;
        int                    len;
        logic                  hit;
        fi  = int'((pc >> 4) % FTB_ENTRIES);
        bi  = int'((pc >> 2) % BHT_ENTRIES);
        hit = ftb_valid[fi] && (ftb_tag[fi] == (pc >> 4) / FTB_ENTRIES);
        blk.start_pc        = pc;
        blk.predicted_taken = hit && (ctr[bi] >= 2);
        if (blk.predicted_taken) begin
            len         = int'(ftb_slot[fi]) + 1;
            blk.next_pc = ftb_target[fi];
        end else begin
            // Short block up to the 4 KB page end
            len         = (pc[11:0] > 12'hff0) ? (32'h1000 - int'(pc[11:0])) / 4 : 4;
            blk.next_pc = pc + 32'(4 * len);
        end
        blk.length          = 3'(len);
        blk.cross_cacheline = (int'(pc[3:2]) + len) > 4;
        return blk;
    endfunction

    function automatic string block_text(input bpu_pkg::fetch_block_t b);
        return $sformatf("start=%h len=%0d taken=%b cross=%b next=%h",
                         b.start_pc, b.length, b.predicted_taken, b.cross_cacheline, b.next_pc);
    endfunction

    ////////////////////
    // Compare and step
    ////////////////////

    // Inputs and outputs are settled at the falling edge
    always @(negedge clk) begin
        bpu_pkg::fetch_block_t expected;
        bpu_pkg::fetch_block_t formed;
        logic                  push_ok;
        int                    fi;
        int                    bi;
        if (rst_i) begin
            for (int i = 0; i < FTB_ENTRIES; i++) begin
                ftb_valid[i] = 1'b0;
            end
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr[i] = 1;
            end
            pending.delete();
            model_pc      = RESET_PC;
            redirect_seen = 1'b0;
            checked_o     = 0;
            errors_o      = 0;
        end else begin
            // Queue room counts before this edge's pop
            push_ok = !redirect_i.valid && (pending.size() < FTQ_DEPTH);
            formed  = predict_block(model_pc);
            if (valid_i !== (pending.size() != 0)) begin
                $display("FAIL %0s: fetch_valid expected %b, actual %b",
                         test_name_i, pending.size() != 0, valid_i);
                errors_o++;
            end
            if (valid_i && ready_i && pending.size() != 0) begin
                expected = pending.pop_front();
                checked_o++;
                if (block_i !== expected) begin
                    $display("FAIL %0s: block expected %0s, actual %0s",
                             test_name_i, block_text(expected), block_text(block_i));
                    errors_o++;
                end
                if (redirect_seen && block_i.start_pc !== redirect_pc) begin
                    $display("FAIL %0s: start after redirect expected %h, actual %h",
                             test_name_i, redirect_pc, block_i.start_pc);
                    errors_o++;
                end
                redirect_seen = 1'b0;
            end
            if (redirect_i.valid) begin
                // Queue flushed, fetch restarts at the new PC
                pending.delete();
                model_pc      = redirect_i.pc;
                redirect_seen = 1'b1;
                redirect_pc   = redirect_i.pc;
            end else if (push_ok) begin
                pending.push_back(formed);
                model_pc = formed.next_pc;
            end
            // Table writes land after this cycle's lookup
            if (train_i.valid) begin
                fi = int'((train_i.start_pc >> 4) % FTB_ENTRIES);
                bi = int'((train_i.start_pc >> 2) % BHT_ENTRIES);
                if (train_i.taken) begin
                    ftb_valid[fi]  = 1'b1;
                    ftb_tag[fi]    = (train_i.start_pc >> 4) / FTB_ENTRIES;
                    ftb_slot[fi]   = train_i.slot;
                    ftb_target[fi] = train_i.target;
                    ctr[bi]        = (ctr[bi] < 3) ? ctr[bi] + 1 : 3;
                end else begin
                    ctr[bi] = (ctr[bi] > 0) ? ctr[bi] - 1 : 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_bpu.sv ====
////////////////////
// Testbench for the branch prediction front end
// Seeded random stimulus and directed tests checked by bpu_checker
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_bpu;

    localparam logic [31:0] RESET_PC     = 32'h8000_0000;
    localparam int          FTB_ENTRIES  = 16;
    localparam int          BHT_ENTRIES  = 64;
    localparam int          FTQ_DEPTH    = 4;
    localparam logic [31:0] SEED         = 32'hd0cd_5d6c;
    // About twice the summed length of the six tests
    localparam int          CYCLE_LIMIT  = 2 * 2000;
    localparam logic [31:0] BR_PC        = 32'h8000_5008;
    localparam logic [31:0] BR_TARGET    = 32'h8000_6000;
    // fetch_ready modes
    localparam int          READY_HIGH   = 0;
    localparam int          READY_LOW    = 1;
    localparam int          READY_RANDOM = 2;

    logic                   clk;
    logic                   rst_i;
    bpu_pkg::bpu_train_t    train;
    bpu_pkg::bpu_redirect_t redirect;
    logic                   fetch_ready;
    logic                   fetch_valid;
    bpu_pkg::fetch_block_t  fetch_block;
    logic [8*24-1:0]        test_name;
    int                     checked;
    int                     errors;
    int                     ready_mode;
    int                     tests_passed;
    int                     tests_failed;
    int                     err_mark;
    int                     chk_mark;
    int                     cycle_count;

    always #20 clk = ~clk;

    bpu_top #(
        .RESET_PC    (RESET_PC),
        .FTB_ENTRIES (FTB_ENTRIES),
        .BHT_ENTRIES (BHT_ENTRIES),
        .FTQ_DEPTH   (FTQ_DEPTH)
    ) UUT (
        .clk           (clk),
        .rst_i         (rst_i),
        .train_i       (train),
        .redirect_i    (redirect),
        .fetch_ready_i (fetch_ready),
        .fetch_valid_o (fetch_valid),
        .fetch_block_o (fetch_block)
    );

    bpu_checker #(
        .RESET_PC    (RESET_PC),
        .FTB_ENTRIES (FTB_ENTRIES),
        .BHT_ENTRIES (BHT_ENTRIES),
        .FTQ_DEPTH   (FTQ_DEPTH)
    ) scoreboard (
        .clk         (clk),
        .rst_i       (rst_i),
        .train_i     (train),
        .redirect_i  (redirect),
        .ready_i     (fetch_ready),
        .valid_i     (fetch_valid),
        .block_i     (fetch_block),
        .test_name_i (test_name),
        .checked_o   (checked),
        .errors_o    (errors)
    );

    ////////////////////
    // Stimulus tasks
    ////////////////////

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        train    = '0;
        redirect = '0;
        case (ready_mode)
            READY_HIGH: fetch_ready = 1'b1;
            READY_LOW:  fetch_ready = 1'b0;
            default:    fetch_ready = ($urandom_range(99) < 70);
        endcase
    endtask

    task automatic train_one(input logic [31:0] pc, input logic [1:0] slot,
                             input logic [31:0] target, input logic taken);
        next_cycle();
        train.valid    = 1'b1;
        train.start_pc = pc;
        train.slot     = slot;
        train.target   = target;
        train.taken    = taken;
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        next_cycle();
        redirect.valid = 1'b1;
        redirect.pc    = pc;
    endtask

    // Wait for n more accepted blocks
    task automatic run_blocks(input int n);
        int goal;
        goal = checked + n;
        while (checked < goal) begin
            next_cycle();
        end
    endtask

    // Aligned PC near a page end, so branches alias and page cuts occur
    function automatic logic [31:0] random_pc();
        return 32'h8000_0f00 + ($urandom_range(127) << 2);
    endfunction

    task automatic begin_test(input logic [8*24-1:0] name);
        test_name = name;
        err_mark  = errors;
        chk_mark  = checked;
    endtask

    task automatic end_test();
        int errs;
        int blocks;
        errs   = errors - err_mark;
        blocks = checked - chk_mark;
        if (errs != 0) begin
            tests_failed++;
            $display("test %0s: failed, %0d errors in %0d blocks", test_name, errs, blocks);
        end else begin
            tests_passed++;
            $display("test %0s: passed, %0d blocks checked", test_name, blocks);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    initial begin
        int goal;
        int pick;
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_i        = 1'b1;
        train        = '0;
        redirect     = '0;
        fetch_ready  = 1'b0;
        ready_mode   = READY_HIGH;
        test_name    = "reset";
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_i       = 1'b0;
        fetch_ready = 1'b1;

        // Sequential blocks from RESET_PC
        begin_test("reset_flow");
        run_blocks(40);
        end_test();

        begin_test("page_cut");
        for (int i = 0; i < 3; i++) begin
            redirect_to(32'h8000_4ff4 + 32'(4 * i));
            run_blocks(3);
        end
        // Random aligned addresses for the line cross flag
        for (int i = 0; i < 20; i++) begin
            redirect_to($urandom & 32'hffff_fffc);
            run_blocks(2);
        end
        end_test();

        // Counter goes 1 to 2, so one update predicts taken
        begin_test("taken_branch");
        train_one(BR_PC, 2'd2, BR_TARGET, 1'b1);
        redirect_to(BR_PC);
        run_blocks(6);
        end_test();

        begin_test("counter_saturation");
        repeat (3) train_one(BR_PC, 2'd2, BR_TARGET, 1'b0);
        redirect_to(BR_PC);
        run_blocks(4);
        // Taken again only after the second update
        for (int i = 0; i < 2; i++) begin
            train_one(BR_PC, 2'd2, BR_TARGET, 1'b1);
            redirect_to(BR_PC);
            run_blocks(4);
        end
        end_test();

        begin_test("random_traffic");
        ready_mode = READY_RANDOM;
        goal       = checked + 400;
        while (checked < goal) begin
            pick = int'($urandom_range(9));
            if (pick == 0) begin
                // Training burst followed by a redirect
                repeat ($urandom_range(3, 1)) begin
                    train_one(random_pc(), 2'($urandom_range(3)), random_pc(),
                              1'($urandom_range(1)));
                end
                redirect_to(random_pc());
            end else if (pick == 1) begin
                redirect_to(random_pc());
            end else begin
                run_blocks(int'($urandom_range(8, 1)));
            end
        end
        end_test();

        // Queue full when the redirect arrives
        begin_test("redirect_flush");
        for (int i = 0; i < 3; i++) begin
            ready_mode = READY_LOW;
            repeat (8) next_cycle();
            redirect_to(32'h8000_7000 + 32'(i * 256));
            ready_mode = READY_HIGH;
            run_blocks(6);
        end
        end_test();

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Hang guard
    initial begin
        for (cycle_count = 0; cycle_count < CYCLE_LIMIT; cycle_count++) begin
            @(posedge clk);
        end
        $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bpu_frontend.f ====
hw/bpu_pkg.sv
hw/ftb.sv
hw/bimodal_predictor.sv
hw/fetch_block_gen.sv
hw/ftq.sv
hw/bpu_top.sv
testbench/bpu_checker.sv
testbench/tb_bpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator, result taken from the log

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --top-module tb_bpu -Mdir obj_dir -f bpu_frontend.f \
    && ./obj_dir/Vtb_bpu > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && exit 1 || exit 0
